// ==== Makefile ====
SIM = verilator
FLAGS = --binary --timing --assert
TOP = pipeTb
FILELIST = list.f
OBJDIR = obj_dir

SOURCES = $(shell cat $(FILELIST))
BIN = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN) pipe_golden.txt
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

// ==== decodeStage.sv ====
`timescale 1ns/100ps

module decodeStage
(
	input logic clk,
	input logic rst,
	input logic advance,
	input mipsPkg::instrWord instrD,
	input logic [mipsPkg::pcWidth-1:0] pcPlus4D,
	input logic [mipsPkg::dataWidth-1:0] aluOutM,
	input mipsPkg::fwdSel fwdAD,
	input mipsPkg::fwdSel fwdBD,
	input logic flushE,
	input logic [4:0] writeRegW,
	input logic [mipsPkg::dataWidth-1:0] resultW,
	input logic regWriteW,
	input logic [4:0] dbgAddr,
	output logic pcSrc,
	output logic [mipsPkg::pcWidth-1:0] branchTarget,
	output logic branchD,
	output logic [4:0] rsD,
	output logic [4:0] rtD,
	output logic [4:0] rsE,
	output logic [4:0] rtE,
	output logic regWriteE,
	output logic memToRegE,
	output logic memWriteE,
	output mipsPkg::aluOp aluOpE,
	output logic aluSrcE,
	output logic regDstE,
	output logic haltE,
	output logic [mipsPkg::dataWidth-1:0] rd1E,
	output logic [mipsPkg::dataWidth-1:0] rd2E,
	output logic [4:0] rdE,
	output logic [mipsPkg::dataWidth-1:0] immE,
	output logic [mipsPkg::dataWidth-1:0] dbgData
);
	import mipsPkg::*;

	logic regWriteD;
	logic memToRegD;
	logic memWriteD;
	logic aluSrcD;
	logic regDstD;
	logic haltD;
	aluOp aluOpD;
	logic [dataWidth-1:0] rd1D;
	logic [dataWidth-1:0] rd2D;
	logic [dataWidth-1:0] immD;
	logic [dataWidth-1:0] cmpA;
	logic [dataWidth-1:0] cmpB;

	assign rsD = instrD.r.rs;
	assign rtD = instrD.r.rt;

	registerFile regs
	(
		.clk(clk),
		.rst(rst),
		.readA(rsD),
		.readB(rtD),
		.writeReg(writeRegW),
		.writeData(resultW),
		.writeEn(regWriteW),
		.dbgAddr(dbgAddr),
		.dataA(rd1D),
		.dataB(rd2D),
		.dbgData(dbgData)
	);

	// ------------------------------
	// Control decode
	// ------------------------------
	// Unknown words fall out as bubbles
	always_comb
	begin
		regWriteD = 1'b0;
		memToRegD = 1'b0;
		memWriteD = 1'b0;
		aluSrcD = 1'b0;
		regDstD = 1'b0;
		branchD = 1'b0;
		haltD = 1'b0;
		aluOpD = aluAdd;
		case (instrD.r.op)
			opRType:
			begin
				regDstD = 1'b1;
				regWriteD = 1'b1;
				case (instrD.r.funct)
					fnAdd: aluOpD = aluAdd;
					fnSub: aluOpD = aluSub;
					fnAnd: aluOpD = aluAnd;
					fnOr: aluOpD = aluOr;
					fnSlt: aluOpD = aluSlt;
					// Includes the all-zero nop
					default: regWriteD = 1'b0;
				endcase
			end
			opAddi:
			begin
				regWriteD = 1'b1;
				aluSrcD = 1'b1;
			end
			opLw:
			begin
				regWriteD = 1'b1;
				memToRegD = 1'b1;
				aluSrcD = 1'b1;
			end
			opSw:
			begin
				memWriteD = 1'b1;
				aluSrcD = 1'b1;
			end
			opBeq: branchD = 1'b1;
			opHalt: haltD = 1'b1;
			default: ;
		endcase
	end

	// Sign extension, branch offset in words
	assign immD = {{16{instrD.i.imm[15]}}, instrD.i.imm};
	assign branchTarget = pcPlus4D + {immD[pcWidth-3:0], 2'b00};

	// Early compare, W results already come through the register file
	assign cmpA = (fwdAD == fwdMem) ? aluOutM : rd1D;
	assign cmpB = (fwdBD == fwdMem) ? aluOutM : rd2D;
	assign pcSrc = branchD && (cmpA == cmpB);

	// ------------------------------
	// ID/EX register
	// ------------------------------
	// Flush turns the entry into a bubble
	always_ff @(posedge clk)
	begin
		if (rst || (advance && flushE))
		begin
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
			memWriteE <= 1'b0;
			aluOpE <= aluAdd;
			aluSrcE <= 1'b0;
			regDstE <= 1'b0;
			haltE <= 1'b0;
		end
		else if (advance)
		begin
			regWriteE <= regWriteD;
			memToRegE <= memToRegD;
			memWriteE <= memWriteD;
			aluOpE <= aluOpD;
			aluSrcE <= aluSrcD;
			regDstE <= regDstD;
			haltE <= haltD;
		end
	end

	// Operands and register numbers
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			rsE <= rsD;
			rtE <= rtD;
			rdE <= instrD.r.rd;
			rd1E <= rd1D;
			rd2E <= rd2D;
			immE <= immD;
		end
	end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/100ps

module executeStage
(
	input logic clk,
	input logic rst,
	input logic advance,
	input logic regWriteE,
	input logic memToRegE,
	input logic memWriteE,
	input mipsPkg::aluOp aluOpE,
	input logic aluSrcE,
	input logic regDstE,
	input logic haltE,
	input logic [mipsPkg::dataWidth-1:0] rd1E,
	input logic [mipsPkg::dataWidth-1:0] rd2E,
	input logic [4:0] rtE,
	input logic [4:0] rdE,
	input logic [mipsPkg::dataWidth-1:0] immE,
	input mipsPkg::fwdSel fwdAE,
	input mipsPkg::fwdSel fwdBE,
	input logic [mipsPkg::dataWidth-1:0] resultW,
	output logic [mipsPkg::dataWidth-1:0] aluOutM,
	output logic [mipsPkg::dataWidth-1:0] writeDataM,
	output logic [4:0] writeRegM,
	output logic [4:0] writeRegE,
	output logic regWriteM,
	output logic memToRegM,
	output logic memWriteM,
	output logic haltM
);
	import mipsPkg::*;

	logic [dataWidth-1:0] srcA;
	logic [dataWidth-1:0] srcB;
	logic [dataWidth-1:0] writeDataE;
	logic [dataWidth-1:0] aluOut;

	// Forwarding mux, same for both operands
	function automatic logic [dataWidth-1:0] pickOperand(input fwdSel sel,
		input logic [dataWidth-1:0] regVal);
		case (sel)
			fwdMem: return aluOutM;
			fwdWb: return resultW;
			default: return regVal;
		endcase
	endfunction

	always_comb
	begin
		srcA = pickOperand(fwdAE, rd1E);
		writeDataE = pickOperand(fwdBE, rd2E);
		// Immediate for addi, lw and sw
		srcB = aluSrcE ? immE : writeDataE;
	end

	// ------------------------------
	// ALU
	// ------------------------------
	always_comb
	begin
		case (aluOpE)
			aluSub: aluOut = srcA - srcB;
			aluAnd: aluOut = srcA & srcB;
			aluOr: aluOut = srcA | srcB;
			aluSlt: aluOut = {{(dataWidth-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			default: aluOut = srcA + srcB;
		endcase
	end

	// rd for R-type, rt for I-type
	assign writeRegE = regDstE ? rdE : rtE;

	// EX/MEM controls
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
			haltM <= 1'b0;
		end
		else if (advance)
		begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
			haltM <= haltE;
		end
	end

	// EX/MEM data
	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			aluOutM <= aluOut;
			writeDataM <= writeDataE;
			writeRegM <= writeRegE;
		end
	end

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/100ps

module fetchStage
(
	input logic clk,
	input logic rst,
	input logic advance,
	input logic stallF,
	input logic stallD,
	input logic pcSrc,
	input logic [mipsPkg::pcWidth-1:0] branchTarget,
	input logic loadEn,
	input logic [$clog2(mipsPkg::imemDepth)-1:0] loadAddr,
	input logic [mipsPkg::dataWidth-1:0] loadData,
	output logic [mipsPkg::pcWidth-1:0] pc,
	output mipsPkg::instrWord instrD,
	output logic [mipsPkg::pcWidth-1:0] pcPlus4D
);
	import mipsPkg::*;

	logic [dataWidth-1:0] imem [imemDepth];
	instrWord instrF;
	logic [pcWidth-1:0] pcPlus4F;
	// Set once a halt has entered decode
	logic haltSeen;

	// Host load port, only path into the memory
	always_ff @(posedge clk)
	begin
		if (loadEn)
			imem[loadAddr] <= loadData;
	end

	// Word index from byte pc; nothing past the halt gets in
	assign instrF = haltSeen ? '0 : imem[pc[pcWidth-1:2]];
	assign pcPlus4F = pc + pcWidth'(4);

	// Program counter
	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (advance && !stallF && !haltSeen)
			pc <= pcSrc ? branchTarget : pcPlus4F;
	end

	// ------------------------------
	// IF/ID register
	// ------------------------------
	// Stall wins over a branch, compare is stale while stalled
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			instrD <= '0;
			haltSeen <= 1'b0;
		end
		else if (advance && !stallD)
		begin
			// Taken beq squashes the wrong-path word to a nop
			instrD <= pcSrc ? '0 : instrF;
			if (!pcSrc && instrF.i.op == opHalt)
				haltSeen <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance && !stallD)
			pcPlus4D <= pcPlus4F;
	end

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/100ps

module hazardUnit
(
	input logic [4:0] rsD,
	input logic [4:0] rtD,
	input logic branchD,
	input logic [4:0] rsE,
	input logic [4:0] rtE,
	input logic [4:0] writeRegE,
	input logic regWriteE,
	input logic memToRegE,
	input logic [4:0] writeRegM,
	input logic regWriteM,
	input logic memToRegM,
	input logic [4:0] writeRegW,
	input logic regWriteW,
	output logic stallF,
	output logic stallD,
	output logic flushE,
	output mipsPkg::fwdSel fwdAD,
	output mipsPkg::fwdSel fwdBD,
	output mipsPkg::fwdSel fwdAE,
	output mipsPkg::fwdSel fwdBE
);
	import mipsPkg::*;

	logic lwStall;
	logic branchStall;

	// M is younger than W, so it wins
	function automatic fwdSel forwardE(input logic [4:0] src);
		if (src != 5'd0 && regWriteM && src == writeRegM)
			return fwdMem;
		else if (src != 5'd0 && regWriteW && src == writeRegW)
			return fwdWb;
		else
			return fwdReg;
	endfunction

	// Branch compare only takes from M, W goes through the regfile bypass
	function automatic fwdSel forwardD(input logic [4:0] src);
		if (src != 5'd0 && regWriteM && src == writeRegM)
			return fwdMem;
		else
			return fwdReg;
	endfunction

	// Same destination check against both decode sources
	function automatic logic usesDest(input logic [4:0] dest);
		return dest != 5'd0 && (dest == rsD || dest == rtD);
	endfunction

	always_comb
	begin
		fwdAE = forwardE(rsE);
		fwdBE = forwardE(rtE);
		fwdAD = forwardD(rsD);
		fwdBD = forwardD(rtD);

		// ------------------------------
		// Stalls
		// ------------------------------
		// Load result not ready until W
		lwStall = memToRegE && usesDest(writeRegE);
		// beq needs operands in D, nothing from E or a load in M
		branchStall = branchD && ((regWriteE && usesDest(writeRegE))
			|| (memToRegM && usesDest(writeRegM)));

		stallF = lwStall || branchStall;
		stallD = lwStall || branchStall;
		// Bubble into E while D holds
		flushE = lwStall || branchStall;
	end

endmodule

// ==== list.f ====
mipsPkg.sv
registerFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
pipe.sv
pipeTb.sv

// ==== memoryStage.sv ====
`timescale 1ns/100ps

module memoryStage
(
	input logic clk,
	input logic rst,
	input logic advance,
	input logic regWriteM,
	input logic memToRegM,
	input logic memWriteM,
	input logic haltM,
	input logic [mipsPkg::dataWidth-1:0] aluOutM,
	input logic [mipsPkg::dataWidth-1:0] writeDataM,
	input logic [4:0] writeRegM,
	output logic [mipsPkg::dataWidth-1:0] resultW,
	output logic [4:0] writeRegW,
	output logic regWriteW,
	output logic done
);
	import mipsPkg::*;

	logic [dataWidth-1:0] dmem [dmemDepth];
	logic [$clog2(dmemDepth)-1:0] wordAddr;
	logic [dataWidth-1:0] readDataW;
	logic [dataWidth-1:0] aluOutW;
	logic memToRegW;
	logic haltW;

	// Whole words only, byte offset dropped
	assign wordAddr = aluOutM[$clog2(dmemDepth)+1:2];

	always_ff @(posedge clk)
	begin
		if (advance && memWriteM)
			dmem[wordAddr] <= writeDataM;
	end

	// ------------------------------
	// MEM/WB register
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
			haltW <= 1'b0;
			done <= 1'b0;
		end
		else if (advance)
		begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
			haltW <= haltM;
			// Sticky until reset, freezes the pipe
			if (haltW)
				done <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			readDataW <= dmem[wordAddr];
			aluOutW <= aluOutM;
			writeRegW <= writeRegM;
		end
	end

	// Write-back select
	assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

// ==== mipsPkg.sv ====
package mipsPkg;

	// ------------------------------
	// Widths and depths
	// ------------------------------
	localparam int dataWidth = 32;
	// Byte address, low two bits always zero
	localparam int pcWidth = 9;
	localparam int imemDepth = 128;
	localparam int dmemDepth = 256;

	// Primary opcodes
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;
	// Stands in for the end flag
	localparam logic [5:0] opHalt = 6'h3f;

	// Function field of R-format words
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	typedef enum logic [3:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp;

	// Operand source: register file, M-stage ALU result, or W-stage result
	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSel;

	// ------------------------------
	// Instruction word, two views
	// ------------------------------
	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [15:0] imm;
	} iFields;

	typedef union packed {
		rFields r;
		iFields i;
	} instrWord;

endpackage

// ==== pipe.sv ====
`timescale 1ns/100ps

module pipe
(
	input logic clk,
	input logic rst,
	input logic run,
	input logic loadEn,
	input logic [$clog2(mipsPkg::imemDepth)-1:0] loadAddr,
	input logic [mipsPkg::dataWidth-1:0] loadData,
	input logic [4:0] dbgAddr,
	output logic [mipsPkg::pcWidth-1:0] pc,
	output logic [mipsPkg::dataWidth-1:0] dbgData,
	output logic done
);
	import mipsPkg::*;

	// Global enable of every pipeline register
	logic advance;

	// ------------------------------
	// Stage wiring
	// ------------------------------
	// IF to ID
	instrWord instrD;
	logic [pcWidth-1:0] pcPlus4D;
	logic pcSrc;
	logic [pcWidth-1:0] branchTarget;

	// ID to EX
	logic branchD;
	logic [4:0] rsD;
	logic [4:0] rtD;
	logic [4:0] rsE;
	logic [4:0] rtE;
	logic [4:0] rdE;
	logic regWriteE;
	logic memToRegE;
	logic memWriteE;
	aluOp aluOpE;
	logic aluSrcE;
	logic regDstE;
	logic haltE;
	logic [dataWidth-1:0] rd1E;
	logic [dataWidth-1:0] rd2E;
	logic [dataWidth-1:0] immE;

	// EX to MEM
	logic [4:0] writeRegE;
	logic [dataWidth-1:0] aluOutM;
	logic [dataWidth-1:0] writeDataM;
	logic [4:0] writeRegM;
	logic regWriteM;
	logic memToRegM;
	logic memWriteM;
	logic haltM;

	// Back from WB
	logic [dataWidth-1:0] resultW;
	logic [4:0] writeRegW;
	logic regWriteW;

	// Hazard controls
	logic stallF;
	logic stallD;
	logic flushE;
	fwdSel fwdAD;
	fwdSel fwdBD;
	fwdSel fwdAE;
	fwdSel fwdBE;

	// Runs only between start and halt
	assign advance = run && !done;

	// Host writes only while stopped
	fetchStage fetch
	(
		.*,
		.loadEn(loadEn && !run)
	);

	decodeStage decode (.*);

	executeStage execute (.*);

	memoryStage memory (.*);

	hazardUnit hazard (.*);

endmodule

// ==== pipeTb.sv ====
`timescale 1ns/100ps

module pipeTb;
	import mipsPkg::*;

	logic clk;
	logic rst;
	logic run;
	logic loadEn;
	logic [$clog2(imemDepth)-1:0] loadAddr;
	logic [dataWidth-1:0] loadData;
	logic [4:0] dbgAddr;
	logic [pcWidth-1:0] pc;
	logic [dataWidth-1:0] dbgData;
	logic done;

	// Program words and expected registers, filled from the golden file
	logic [$clog2(imemDepth)-1:0] progAddr [$];
	logic [dataWidth-1:0] progWord [$];
	logic [4:0] regNum [$];
	logic [dataWidth-1:0] regValue [$];

	pipe dut (.*);

	// 20 ns period
	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ------------------------------
	// Checking
	// ------------------------------
	task automatic expectValue(input string what, input logic [dataWidth-1:0] got,
		input logic [dataWidth-1:0] want);
		assert (got === want)
		else
		begin
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, want);
			$display("Errors found");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// I lines go to the program, R lines to the expected registers
	task automatic readGolden();
		int fd;
		int code;
		logic [7:0] tag;
		logic [dataWidth-1:0] first;
		logic [dataWidth-1:0] second;
		logic [8*128-1:0] rest;
		fd = $fopen("pipe_golden.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open pipe_golden.txt for reading");
			$display("Errors found");
			$fatal(1, "golden file missing");
		end
		else
		begin
			while ($fscanf(fd, "%s", tag) == 1)
			begin
				// Comment lines, rest of line dropped
				if (tag == "#")
					code = $fgets(rest, fd);
				else
				begin
					code = $fscanf(fd, "%h %h", first, second);
					if (code != 2 || (tag != "I" && tag != "R"))
					begin
						$display("Malformed line in pipe_golden.txt, tag %s", tag);
						$display("Errors found");
						$fatal(1, "bad golden file");
					end
					else if (tag == "I")
					begin
						progAddr.push_back(first[$clog2(imemDepth)-1:0]);
						progWord.push_back(second);
					end
					else
					begin
						regNum.push_back(first[4:0]);
						regValue.push_back(second);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ------------------------------
	// Phases
	// ------------------------------
	// One word per cycle through the host port, pipe must stay parked
	task automatic loadProgram();
		for (int i = 0; i < progAddr.size(); i++)
		begin
			@(posedge clk);
			loadEn <= 1'b1;
			loadAddr <= progAddr[i];
			loadData <= progWord[i];
			@(negedge clk);
			expectValue("pc during load", 32'(pc), '0);
			expectValue("done during load", 32'(done), '0);
		end
		@(posedge clk);
		loadEn <= 1'b0;
	endtask

	// Halt reaching write-back ends the run
	task automatic waitForDone();
		int cycles;
		cycles = 0;
		while (!done && cycles < 500)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!done)
		begin
			$display("Timeout: done did not rise within 500 cycles of run");
			$display("Errors found");
			$fatal(1, "pipeline never halted");
		end
	endtask

	// Debug port is combinational, sample mid-cycle
	task automatic compareRegisters();
		string what;
		for (int i = 0; i < regNum.size(); i++)
		begin
			@(posedge clk);
			dbgAddr <= regNum[i];
			@(negedge clk);
			what = $sformatf("register %0d", regNum[i]);
			expectValue(what, dbgData, regValue[i]);
		end
	endtask

	initial
	begin
		rst = 1'b1;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		dbgAddr = '0;
		readGolden();

		// Two reset edges
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		expectValue("pc after reset", 32'(pc), '0);
		expectValue("done after reset", 32'(done), '0);

		loadProgram();
		run <= 1'b1;
		waitForDone();

		compareRegisters();
		// Sticky until the next reset
		expectValue("done after compare", 32'(done), 32'd1);

		$display("No errors");
		$finish;
	end

endmodule

// ==== pipe_golden.txt ====
# I <word address> <instruction word>, hex
# R <register> <expected value>, hex
I 00 20010005
I 01 2002fffd
I 02 00221820
I 03 00612022
I 04 00812824
I 05 00433025
I 06 0041382a
I 07 0022402a
I 08 ac040010
I 09 8c090010
I 0a 00295022
I 0b 200b0007
I 0c 200c0005
I 0d 11810002
I 0e 200d0063
I 0f 200e004d
I 10 11610001
I 11 200f0021
I 12 2000002a
I 13 fc000000
# Register values after the halt
R 00 00000000
R 01 00000005
R 02 fffffffd
R 03 00000002
R 04 fffffffd
R 05 00000005
R 06 ffffffff
R 07 00000001
R 08 00000000
R 09 fffffffd
R 0a 00000008
R 0b 00000007
R 0c 00000005
R 0d 00000000
R 0e 00000000
R 0f 00000021

// ==== registerFile.sv ====
`timescale 1ns/100ps

module registerFile
(
	input logic clk,
	input logic rst,
	input logic [4:0] readA,
	input logic [4:0] readB,
	input logic [4:0] writeReg,
	input logic [mipsPkg::dataWidth-1:0] writeData,
	input logic writeEn,
	input logic [4:0] dbgAddr,
	output logic [mipsPkg::dataWidth-1:0] dataA,
	output logic [mipsPkg::dataWidth-1:0] dataB,
	output logic [mipsPkg::dataWidth-1:0] dbgData
);
	import mipsPkg::*;

	logic [dataWidth-1:0] regs [32];

	// Register 0 hardwired, same-cycle write goes straight through
	function automatic logic [dataWidth-1:0] readPort(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		else if (writeEn && writeReg == addr)
			return writeData;
		else
			return regs[addr];
	endfunction

	always_comb
	begin
		dataA = readPort(readA);
		dataB = readPort(readB);
		dbgData = readPort(dbgAddr);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEn && writeReg != 5'd0)
			regs[writeReg] <= writeData;
	end

endmodule
